/* design/rgb_console_consts.svh */
`ifndef RGB_CONSOLE_CONSTS_SVH
`define RGB_CONSOLE_CONSTS_SVH

// Serial framing
`define RC_DATA_BITS 8
`define RC_OVERSAMPLE 16

// 9600 baud from a 50 MHz clock
`define RC_CLKS_PER_BIT_DEFAULT 5208

// Command length counts the terminator
`define RC_CMD_LENGTH 7
`define RC_HISTORY_DEPTH 6

// Lamp intensity and PWM resolution
`define RC_LEVEL_BITS 2
`define RC_PWM_BITS 3

`endif

/* design/rgb_console_pkg.sv */
`include "rgb_console_consts.svh"

package rgb_console_pkg;

    // One UART character
    typedef logic [`RC_DATA_BITS-1:0] byte_t;

    // Lamp intensity, 0 to 3
    typedef logic [`RC_LEVEL_BITS-1:0] level_t;

    // Serial framing phases, shared by receiver and transmitter
    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_t;

    // Console control flow
    typedef enum logic [1:0] {
        seq_print_ready,
        seq_await_cmd,
        seq_apply_cmd,
        seq_print_ack
    } seq_state_t;

endpackage

/* design/baud_tick_gen.sv */
`timescale 1ns/10ps

module baud_tick_gen #(
    parameter int period = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic clear,
    output logic tick
);

    localparam int cnt_bits = (period > 1) ? $clog2(period) : 1;

    logic [cnt_bits-1:0] count;

    // Wraps on the tick cycle so the spacing is exactly period clocks
    always_ff @(posedge clock) begin
        if (reset || clear || tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign tick = (count == cnt_bits'(period - 1));

endmodule

/* design/uart_rx.sv */
`timescale 1ns/10ps
`include "rgb_console_consts.svh"

module uart_rx #(
    parameter int clks_per_bit = `RC_CLKS_PER_BIT_DEFAULT
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   rx,
    output rgb_console_pkg::byte_t rx_byte,
    output logic                   rx_done
);

    localparam int tick_bits = $clog2(`RC_OVERSAMPLE);
    localparam int bit_bits = $clog2(`RC_DATA_BITS);
    localparam logic [tick_bits-1:0] mid_tick = tick_bits'(`RC_OVERSAMPLE / 2 - 1);
    localparam logic [tick_bits-1:0] last_tick = tick_bits'(`RC_OVERSAMPLE - 1);
    localparam logic [bit_bits-1:0] last_bit = bit_bits'(`RC_DATA_BITS - 1);

    rgb_console_pkg::uart_state_t state;
    logic [tick_bits-1:0]         tick_cnt;
    logic [bit_bits-1:0]          bit_cnt;
    logic                         sample_tick;
    logic [1:0]                   rx_sync;
    logic                         rx_line;
    logic                         sample_bit;

    // Oversampling tick runs freely, so start detection jitters by one tick
    baud_tick_gen #(
        .period(clks_per_bit / `RC_OVERSAMPLE)
    ) i_tick (
        .clock(clock),
        .reset(reset),
        .clear(1'b0),
        .tick (sample_tick)
    );

    // Line is asynchronous to clock
    always_ff @(posedge clock) begin
        if (reset) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    assign rx_line = rx_sync[1];
    assign sample_bit = (state == rgb_console_pkg::uart_data) && sample_tick
                        && (tick_cnt == last_tick);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= rgb_console_pkg::uart_idle;
            tick_cnt <= '0;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                rgb_console_pkg::uart_idle: begin
                    if (!rx_line) begin
                        state <= rgb_console_pkg::uart_start;
                        tick_cnt <= '0;
                    end
                end
                // Walk to the middle of the start bit
                rgb_console_pkg::uart_start: begin
                    if (sample_tick) begin
                        if (tick_cnt == mid_tick) begin
                            state <= rgb_console_pkg::uart_data;
                            tick_cnt <= '0;
                            bit_cnt <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                rgb_console_pkg::uart_data: begin
                    if (sample_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == last_tick) begin
                            if (bit_cnt == last_bit) begin
                                state <= rgb_console_pkg::uart_stop;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                rgb_console_pkg::uart_stop: begin
                    if (sample_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == last_tick) begin
                            rx_done <= 1'b1;
                            state <= rgb_console_pkg::uart_idle;
                        end
                    end
                end
                default: state <= rgb_console_pkg::uart_idle;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clock) begin
        if (sample_bit) begin
            rx_byte <= {rx_line, rx_byte[`RC_DATA_BITS-1:1]};
        end
    end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/10ps
`include "rgb_console_consts.svh"

module uart_tx #(
    parameter int clks_per_bit = `RC_CLKS_PER_BIT_DEFAULT
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   tx_start,
    input  rgb_console_pkg::byte_t tx_byte,
    output logic                   tx,
    output logic                   tx_done
);

    localparam int bit_bits = $clog2(`RC_DATA_BITS);
    localparam logic [bit_bits-1:0] last_bit = bit_bits'(`RC_DATA_BITS - 1);

    rgb_console_pkg::uart_state_t state;
    rgb_console_pkg::byte_t       data_reg;
    logic [bit_bits-1:0]          bit_cnt;
    logic                         bit_tick;
    logic                         idle;

    assign idle = (state == rgb_console_pkg::uart_idle);

    // Held in clear while idle so the first bit is a full period
    baud_tick_gen #(
        .period(clks_per_bit)
    ) i_tick (
        .clock(clock),
        .reset(reset),
        .clear(idle),
        .tick (bit_tick)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= rgb_console_pkg::uart_idle;
            bit_cnt <= '0;
            tx <= 1'b1;
        end else begin
            case (state)
                rgb_console_pkg::uart_idle: begin
                    if (tx_start) begin
                        state <= rgb_console_pkg::uart_start;
                        tx <= 1'b0;
                    end
                end
                rgb_console_pkg::uart_start: begin
                    if (bit_tick) begin
                        state <= rgb_console_pkg::uart_data;
                        bit_cnt <= '0;
                        tx <= data_reg[0];
                    end
                end
                rgb_console_pkg::uart_data: begin
                    if (bit_tick) begin
                        if (bit_cnt == last_bit) begin
                            state <= rgb_console_pkg::uart_stop;
                            tx <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx <= data_reg[0];
                        end
                    end
                end
                rgb_console_pkg::uart_stop: begin
                    if (bit_tick) begin
                        state <= rgb_console_pkg::uart_idle;
                    end
                end
                default: state <= rgb_console_pkg::uart_idle;
            endcase
        end
    end

    // Next data bit always sits in bit 0
    always_ff @(posedge clock) begin
        if (idle && tx_start) begin
            data_reg <= tx_byte;
        end else if (bit_tick && !idle) begin
            data_reg <= data_reg >> 1;
        end
    end

    assign tx_done = (state == rgb_console_pkg::uart_stop) && bit_tick;

endmodule

/* design/command_buffer.sv */
`timescale 1ns/10ps
`include "rgb_console_consts.svh"

module command_buffer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    armed,
    input  rgb_console_pkg::byte_t  rx_byte,
    input  logic                    rx_done,
    output logic                    cmd_ready,
    output rgb_console_pkg::level_t red_level,
    output rgb_console_pkg::level_t green_level,
    output rgb_console_pkg::level_t blue_level
);

    localparam int cnt_bits = $clog2(`RC_CMD_LENGTH);
    localparam logic [cnt_bits-1:0] last_byte = cnt_bits'(`RC_CMD_LENGTH - 1);

    // Position 0 holds the newest byte
    rgb_console_pkg::byte_t history [`RC_HISTORY_DEPTH];
    logic [cnt_bits-1:0]    byte_cnt;
    logic                   accept;

    function automatic rgb_console_pkg::level_t digit_level(input rgb_console_pkg::byte_t c);
        // '0' to '3' carry their value in the low two bits
        if (c >= "0" && c <= "3") begin
            return c[`RC_LEVEL_BITS-1:0];
        end
        return '0;
    endfunction

    assign accept = armed && rx_done;
    assign cmd_ready = accept && (byte_cnt == last_byte);

    always_ff @(posedge clock) begin
        if (reset || !armed) begin
            byte_cnt <= '0;
            for (int i = 0; i < `RC_HISTORY_DEPTH; i++) begin
                history[i] <= '0;
            end
        end else if (cmd_ready) begin
            // Terminator is not stored, so the digits stay put for apply
            byte_cnt <= '0;
        end else if (accept) begin
            byte_cnt <= byte_cnt + 1'b1;
            for (int i = `RC_HISTORY_DEPTH - 1; i > 0; i--) begin
                history[i] <= history[i-1];
            end
            history[0] <= rx_byte;
        end
    end

    assign red_level = digit_level(history[4]);
    assign green_level = digit_level(history[2]);
    assign blue_level = digit_level(history[0]);

endmodule

/* design/console_sequencer.sv */
`timescale 1ns/10ps

module console_sequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    tx_done,
    input  logic                    cmd_ready,
    input  rgb_console_pkg::level_t red_level_in,
    input  rgb_console_pkg::level_t green_level_in,
    input  rgb_console_pkg::level_t blue_level_in,
    output logic                    tx_start,
    output rgb_console_pkg::byte_t  tx_byte,
    output logic                    armed,
    output rgb_console_pkg::level_t red_level,
    output rgb_console_pkg::level_t green_level,
    output rgb_console_pkg::level_t blue_level
);

    localparam logic [4:0] ready_last = 5'd6;
    localparam logic [4:0] ack_first = 5'd8;
    localparam logic [4:0] ack_last = 5'd16;

    rgb_console_pkg::seq_state_t state, state_next;
    logic [4:0] msg_index, msg_index_next;
    logic       started, started_next;
    logic       tx_start_next;

    // "Ready" LF CR at 0..6, "Control" LF CR at 8..16
    function automatic rgb_console_pkg::byte_t msg_char(input logic [4:0] idx);
        case (idx)
            5'd0:  return "R";
            5'd1:  return "e";
            5'd2:  return "a";
            5'd3:  return "d";
            5'd4:  return "y";
            5'd5:  return 8'h0a;
            5'd6:  return 8'h0d;
            5'd8:  return "C";
            5'd9:  return "o";
            5'd10: return "n";
            5'd11: return "t";
            5'd12: return "r";
            5'd13: return "o";
            5'd14: return "l";
            5'd15: return 8'h0a;
            5'd16: return 8'h0d;
            default: return 8'h00;
        endcase
    endfunction

    always_comb begin
        state_next = state;
        msg_index_next = msg_index;
        started_next = started;
        tx_start_next = 1'b0;
        case (state)
            rgb_console_pkg::seq_print_ready: begin
                if (!started) begin
                    tx_start_next = 1'b1;
                    started_next = 1'b1;
                end else if (tx_done) begin
                    if (msg_index == ready_last) begin
                        state_next = rgb_console_pkg::seq_await_cmd;
                        started_next = 1'b0;
                    end else begin
                        msg_index_next = msg_index + 1'b1;
                        tx_start_next = 1'b1;
                    end
                end
            end
            rgb_console_pkg::seq_await_cmd: begin
                if (cmd_ready) begin
                    state_next = rgb_console_pkg::seq_apply_cmd;
                end
            end
            rgb_console_pkg::seq_apply_cmd: begin
                state_next = rgb_console_pkg::seq_print_ack;
                msg_index_next = ack_first;
                tx_start_next = 1'b1;
                started_next = 1'b1;
            end
            rgb_console_pkg::seq_print_ack: begin
                if (tx_done) begin
                    tx_start_next = 1'b1;
                    if (msg_index == ack_last) begin
                        // Straight back into the prompt
                        state_next = rgb_console_pkg::seq_print_ready;
                        msg_index_next = '0;
                    end else begin
                        msg_index_next = msg_index + 1'b1;
                    end
                end
            end
            default: state_next = rgb_console_pkg::seq_print_ready;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= rgb_console_pkg::seq_print_ready;
            msg_index <= '0;
            started <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            state <= state_next;
            msg_index <= msg_index_next;
            started <= started_next;
            tx_start <= tx_start_next;
        end
    end

    // Buffer still holds the digits during apply
    always_ff @(posedge clock) begin
        if (reset) begin
            red_level <= '0;
            green_level <= '0;
            blue_level <= '0;
        end else if (state == rgb_console_pkg::seq_apply_cmd) begin
            red_level <= red_level_in;
            green_level <= green_level_in;
            blue_level <= blue_level_in;
        end
    end

    assign tx_byte = msg_char(msg_index);
    assign armed = (state == rgb_console_pkg::seq_await_cmd);

endmodule

/* design/rgb_pwm.sv */
`timescale 1ns/10ps
`include "rgb_console_consts.svh"

module rgb_pwm (
    input  logic                    clock,
    input  logic                    reset,
    input  rgb_console_pkg::level_t red_level,
    input  rgb_console_pkg::level_t green_level,
    input  rgb_console_pkg::level_t blue_level,
    output logic                    pwm_red,
    output logic                    pwm_green,
    output logic                    pwm_blue
);

    localparam int pwm_bits = `RC_PWM_BITS;

    logic [pwm_bits-1:0] pwm_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            pwm_count <= '0;
        end else begin
            pwm_count <= pwm_count + 1'b1;
        end
    end

    // Level L stays high for L of every 8 counts
    assign pwm_red = (pwm_count < pwm_bits'(red_level));
    assign pwm_green = (pwm_count < pwm_bits'(green_level));
    assign pwm_blue = (pwm_count < pwm_bits'(blue_level));

endmodule

/* design/rgb_uart_console.sv */
`timescale 1ns/10ps
`include "rgb_console_consts.svh"

module rgb_uart_console #(
    parameter int clks_per_bit = `RC_CLKS_PER_BIT_DEFAULT
) (
    input  logic clock,
    input  logic reset,
    input  logic uart_rx,
    output logic uart_tx,
    output logic pwm_red,
    output logic pwm_green,
    output logic pwm_blue
);

    rgb_console_pkg::byte_t  rx_byte;
    rgb_console_pkg::byte_t  tx_byte;
    logic                    rx_done;
    logic                    tx_start;
    logic                    tx_done;
    logic                    armed;
    logic                    cmd_ready;
    rgb_console_pkg::level_t cmd_red, cmd_green, cmd_blue;
    rgb_console_pkg::level_t red_level, green_level, blue_level;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) i_rx (
        .clock  (clock),
        .reset  (reset),
        .rx     (uart_rx),
        .rx_byte(rx_byte),
        .rx_done(rx_done)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) i_tx (
        .clock   (clock),
        .reset   (reset),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .tx      (uart_tx),
        .tx_done (tx_done)
    );

    command_buffer i_cmd (
        .clock      (clock),
        .reset      (reset),
        .armed      (armed),
        .rx_byte    (rx_byte),
        .rx_done    (rx_done),
        .cmd_ready  (cmd_ready),
        .red_level  (cmd_red),
        .green_level(cmd_green),
        .blue_level (cmd_blue)
    );

    console_sequencer i_seq (
        .clock         (clock),
        .reset         (reset),
        .tx_done       (tx_done),
        .cmd_ready     (cmd_ready),
        .red_level_in  (cmd_red),
        .green_level_in(cmd_green),
        .blue_level_in (cmd_blue),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .armed         (armed),
        .red_level     (red_level),
        .green_level   (green_level),
        .blue_level    (blue_level)
    );

    rgb_pwm i_pwm (
        .clock      (clock),
        .reset      (reset),
        .red_level  (red_level),
        .green_level(green_level),
        .blue_level (blue_level),
        .pwm_red    (pwm_red),
        .pwm_green  (pwm_green),
        .pwm_blue   (pwm_blue)
    );

endmodule

/* sim/tb_rgb_uart_console.sv */
`timescale 1ns/10ps

module tb_rgb_uart_console;

    localparam int clks_per_bit = 64;
    localparam int gap_max = 200;
    localparam int bytes_per_test = 25;

    logic        clock;
    logic        reset;
    logic        rx_line;
    logic        tx_line;
    logic        pwm_red;
    logic        pwm_green;
    logic        pwm_blue;
    logic [31:0] lcg_state;
    int          cycle_count;
    int          cycle_limit;

    // Seven command bytes and three levels per test
    string       test_names[$];
    logic [7:0]  cmd_bytes[$];
    int          exp_levels[$];

    rgb_uart_console #(
        .clks_per_bit(clks_per_bit)
    ) i_dut (
        .clock    (clock),
        .reset    (reset),
        .uart_rx  (rx_line),
        .uart_tx  (tx_line),
        .pwm_red  (pwm_red),
        .pwm_green(pwm_green),
        .pwm_blue (pwm_blue)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Random idle gap, then start bit, data LSB first, stop bit
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        int         gap;
        int         i;
        frame = {1'b1, value, 1'b0};
        gap = (next_random() >> 16) % (gap_max + 1);
        repeat (gap) @(posedge clock);
        for (i = 0; i < 10; i++) begin
            @(posedge clock);
            rx_line <= frame[i];
            repeat (clks_per_bit - 1) @(posedge clock);
        end
    endtask

    task automatic send_command(input int test);
        int i;
        for (i = 0; i < 7; i++) begin
            send_byte(cmd_bytes[test * 7 + i]);
        end
    endtask

    // Returns at the middle of the stop bit
    task automatic receive_byte(input string test_name, output logic [7:0] value);
        logic [7:0] data;
        int         i;
        @(negedge clock);
        while (tx_line !== 1'b0) @(negedge clock);
        repeat (clks_per_bit / 2) @(negedge clock);
        check_value(test_name, "start bit", 0, tx_line);
        for (i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clock);
            data[i] = tx_line;
        end
        repeat (clks_per_bit) @(negedge clock);
        check_value(test_name, "stop bit", 1, tx_line);
        value = data;
    endtask

    // Text followed by LF and CR
    task automatic expect_text(input string test_name, input string text);
        logic [7:0] got;
        int         i;
        for (i = 0; i < text.len(); i++) begin
            receive_byte(test_name, got);
            check_value(test_name, $sformatf("character %0d of %s", i, text), text[i], got);
        end
        receive_byte(test_name, got);
        check_value(test_name, $sformatf("line feed after %s", text), 8'h0a, got);
        receive_byte(test_name, got);
        check_value(test_name, $sformatf("carriage return after %s", text), 8'h0d, got);
    endtask

    task automatic check_pwm_low(input string test_name, input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clock);
            check_value(test_name, "pwm_red after reset", 0, pwm_red);
            check_value(test_name, "pwm_green after reset", 0, pwm_green);
            check_value(test_name, "pwm_blue after reset", 0, pwm_blue);
        end
    endtask

    // Every 8-cycle window inside 16 samples must hold level high cycles
    task automatic check_duty(input string test_name, input int red, input int green,
                              input int blue);
        logic [2:0] samples [16];
        int         expected [3];
        string      channel [3];
        int         start;
        int         ch;
        int         k;
        int         count;
        expected = '{red, green, blue};
        channel = '{"pwm_red", "pwm_green", "pwm_blue"};
        for (k = 0; k < 16; k++) begin
            @(negedge clock);
            samples[k] = {pwm_blue, pwm_green, pwm_red};
        end
        for (start = 0; start <= 8; start++) begin
            for (ch = 0; ch < 3; ch++) begin
                count = 0;
                for (k = start; k < start + 8; k++) begin
                    count += samples[k][ch];
                end
                check_value(test_name, $sformatf("%s high cycles from sample %0d",
                            channel[ch], start), expected[ch], count);
            end
        end
    endtask

    initial begin
        int         fd;
        int         code;
        int         n;
        int         t;
        int         red;
        int         green;
        int         blue;
        string      line;
        string      name;
        logic [7:0] cmd [7];
        rx_line = 1'b1;
        reset = 1'b1;
        cycle_count = 0;
        cycle_limit = 0;
        lcg_state = 32'h89f6;
        fd = $fopen("sim/rgb_console_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/rgb_console_stim.txt");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %d %d %d", name, cmd[0], cmd[1],
                            cmd[2], cmd[3], cmd[4], cmd[5], cmd[6], red, green, blue);
                if (n == 11) begin
                    test_names.push_back(name);
                    for (t = 0; t < 7; t++) begin
                        cmd_bytes.push_back(cmd[t]);
                    end
                    exp_levels.push_back(red);
                    exp_levels.push_back(green);
                    exp_levels.push_back(blue);
                end
            end
        end
        $fclose(fd);
        if (test_names.size() == 0) begin
            $display("The stimulus file holds no test lines");
            $display("SIMULATION FAILED");
            $fatal(1);
        end

        // Bytes per test, worst-case gaps, one spare test
        cycle_limit = test_names.size() * bytes_per_test * 10 * clks_per_bit
                      + test_names.size() * 7 * gap_max
                      + bytes_per_test * 10 * clks_per_bit;

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        fork
            expect_text("reset", "Ready");
            check_pwm_low("reset", 16);
        join

        for (t = 0; t < test_names.size(); t++) begin
            // Reply starts while the terminator's stop bit is still on the line
            fork
                send_command(t);
                expect_text(test_names[t], "Control");
            join
            fork
                expect_text(test_names[t], "Ready");
                check_duty(test_names[t], exp_levels[t * 3], exp_levels[t * 3 + 1],
                           exp_levels[t * 3 + 2]);
            join
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* rgb_console.f */
+incdir+design
design/rgb_console_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/command_buffer.sv
design/console_sequencer.sv
design/rgb_pwm.sv
design/rgb_uart_console.sv
sim/tb_rgb_uart_console.sv

/* Bender.yml */
package:
  name: rgb_console

export_include_dirs:
  - design

sources:
  - design/rgb_console_pkg.sv
  - design/baud_tick_gen.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/command_buffer.sv
  - design/console_sequencer.sv
  - design/rgb_pwm.sv
  - design/rgb_uart_console.sv
  - target: simulation
    files:
      - sim/tb_rgb_uart_console.sv

/* sim/rgb_console_stim.txt */
# name, seven command bytes in hex (terminator last), expected red green blue levels
# digits '0' to '3' in bytes 2, 4 and 6 set the level, anything else gives 0
basic_123 52 31 47 32 42 33 0d 1 2 3
all_max 52 33 47 33 42 33 0d 3 3 3
red_only 52 33 47 30 42 30 0d 3 0 0
green_only 52 30 47 33 42 30 0d 0 3 0
blue_only 52 30 47 30 42 33 0d 0 0 3
digit_seven 52 37 47 32 42 31 0d 0 2 1
letters 52 78 47 33 42 5a 0d 0 3 0
digit_four 52 34 47 33 42 32 0d 0 3 2
punctuation 52 3a 47 2f 42 33 0d 0 0 3
descending 52 32 47 31 42 30 0d 2 1 0
all_off 52 30 47 30 42 30 0d 0 0 0
other_labels 41 31 41 31 41 31 0a 1 1 1
digit_nine 52 31 47 39 42 32 0d 1 0 2
high_bit_set 52 b1 47 32 42 33 0d 0 2 3
two_three_two 52 32 47 33 42 32 0d 2 3 2
final_off 52 30 47 30 42 30 0d 0 0 0
